// ==== board_top.f ====
design/board_pkg.sv
design/lcd_if.sv
design/power_on_reset.sv
design/slow_tick_gen.sv
design/lcd_timing.sv
design/board_io_adapter.sv
design/lab_top.sv
design/board_top.sv
verification/tb_clock_gen.sv
verification/tb_board_top.sv

// ==== design/board_io_adapter.sv ====
`default_nettype none

module board_io_adapter
    import board_pkg::*;
#(
    parameter int screen_width  = 480,
    parameter int screen_height = 272
)
(
    input  wire  [W_KEY - 1:0] i_key,      // Active low pins
    output logic [W_KEY - 1:0] o_lab_key,

    input  wire  [W_LED - 1:0] i_lab_led,
    output logic [W_LED - 1:0] o_led,      // Active low pins

    lcd_if.sink                lcd_in,
    lcd_if.source              lcd_out
);

    localparam int w_x = $clog2(screen_width);
    localparam int w_y = $clog2(screen_height);

    //----------------------------------------------------------------------
    // Keys and LEDs are wired in reverse order on this board

    assign o_lab_key = {<<{~i_key}};
    assign o_led     = {<<{~i_lab_led}};

    //----------------------------------------------------------------------
    // Panel is mounted upside down

    assign lcd_out.x  = w_x'(screen_width  - 1 - lcd_in.x);
    assign lcd_out.y  = w_y'(screen_height - 1 - lcd_in.y);

    assign lcd_out.de = lcd_in.de;
    assign lcd_out.hs = lcd_in.hs;
    assign lcd_out.vs = lcd_in.vs;

endmodule

`default_nettype wire

// ==== design/board_pkg.sv ====
`default_nettype none

package board_pkg;

    //----------------------------------------------------------------------
    // Board I/O widths

    localparam int W_KEY   = 2;  // Push buttons
    localparam int W_LED   = 6;

    //----------------------------------------------------------------------
    // RGB565 pixel word of the LCD

    localparam int W_RED   = 5;
    localparam int W_GREEN = 6;
    localparam int W_BLUE  = 5;

    localparam int W_PIXEL = W_RED + W_GREEN + W_BLUE;

    typedef struct packed
    {
        logic [W_RED   - 1:0] red;    // Upper bits
        logic [W_GREEN - 1:0] green;
        logic [W_BLUE  - 1:0] blue;
    } rgb_t;

    // Same 16 bits seen as fields or as one raw word
    typedef union packed
    {
        logic [W_PIXEL - 1:0] raw;
        rgb_t                 rgb;
    } pixel_t;

endpackage

`default_nettype wire

// ==== design/board_top.sv ====
`default_nettype none

module board_top
    import board_pkg::*;
#(
    parameter int tick_period   = 27_000_000,
    parameter int reset_cycles  = 16,

    parameter int screen_width  = 480,
    parameter int screen_height = 272,
    parameter int h_front       = 8,
    parameter int h_sync        = 4,
    parameter int h_back        = 43,
    parameter int v_front       = 8,
    parameter int v_sync        = 4,
    parameter int v_back        = 12
)
(
    input  wire                  clk,
    input  wire                  i_rst_n,
    input  wire  [W_KEY   - 1:0] i_key,

    output logic [W_LED   - 1:0] o_led,

    output logic                 o_lcd_de,
    output logic                 o_lcd_hs,
    output logic                 o_lcd_vs,
    output logic [W_RED   - 1:0] o_lcd_r,
    output logic [W_GREEN - 1:0] o_lcd_g,
    output logic [W_BLUE  - 1:0] o_lcd_b
);

    localparam int w_x = $clog2(screen_width);
    localparam int w_y = $clog2(screen_height);

    logic               rst;
    logic               tick;
    logic [W_KEY - 1:0] lab_key;
    logic [W_LED - 1:0] lab_led;
    pixel_t             pixel;

    lcd_if #(.w_x(w_x), .w_y(w_y)) lcd_raw ();
    lcd_if #(.w_x(w_x), .w_y(w_y)) lcd_mirrored ();

    //----------------------------------------------------------------------
    // Reset and slow strobe

    power_on_reset #(.reset_cycles(reset_cycles)) i_power_on_reset
    (
        .clk     ( clk     ),
        .i_rst_n ( i_rst_n ),
        .o_rst   ( rst     )
    );

    slow_tick_gen #(.tick_period(tick_period)) i_slow_tick_gen
    (
        .clk    ( clk  ),
        .i_rst  ( rst  ),
        .o_tick ( tick )
    );

    //----------------------------------------------------------------------
    // Display timing and pin adaptation

    lcd_timing
    #(
        .screen_width  ( screen_width  ),
        .screen_height ( screen_height ),
        .h_front       ( h_front       ),
        .h_sync        ( h_sync        ),
        .h_back        ( h_back        ),
        .v_front       ( v_front       ),
        .v_sync        ( v_sync        ),
        .v_back        ( v_back        )
    )
    i_lcd_timing
    (
        .clk   ( clk            ),
        .i_rst ( rst            ),
        .lcd   ( lcd_raw.source )
    );

    board_io_adapter
    #(
        .screen_width  ( screen_width  ),
        .screen_height ( screen_height )
    )
    i_board_io_adapter
    (
        .i_key     ( i_key               ),
        .o_lab_key ( lab_key             ),
        .i_lab_led ( lab_led             ),
        .o_led     ( o_led               ),
        .lcd_in    ( lcd_raw.sink        ),
        .lcd_out   ( lcd_mirrored.source )
    );

    //----------------------------------------------------------------------

    lab_top i_lab_top
    (
        .clk       ( clk               ),
        .i_rst     ( rst               ),
        .i_tick    ( tick              ),
        .i_lab_key ( lab_key           ),
        .o_lab_led ( lab_led           ),
        .lcd       ( lcd_mirrored.sink ),
        .o_pixel   ( pixel             )
    );

    assign o_lcd_de = lcd_mirrored.de;
    assign o_lcd_hs = lcd_mirrored.hs;
    assign o_lcd_vs = lcd_mirrored.vs;

    assign o_lcd_r  = pixel.rgb.red;    // Zero outside active area
    assign o_lcd_g  = pixel.rgb.green;
    assign o_lcd_b  = pixel.rgb.blue;

endmodule

`default_nettype wire

// ==== design/lab_top.sv ====
`default_nettype none

module lab_top
    import board_pkg::*;
(
    input  wire  clk,
    input  wire  i_rst,
    input  wire  i_tick,                   // One cycle strobe
    input  wire  [W_KEY - 1:0] i_lab_key,  // Active high

    output logic [W_LED - 1:0] o_lab_led,

    lcd_if.sink  lcd,
    output pixel_t o_pixel
);

    logic [W_LED - 1:0] count;

    //----------------------------------------------------------------------
    // Tick counter, clear wins over increment

    always_ff @(posedge clk or posedge i_rst)
    begin
        if (i_rst)
            count <= '0;
        else if (i_lab_key[1])
            count <= '0;
        else if (i_tick && i_lab_key[0])
            count <= count + 1'b1;  // Wraps at 64
    end

    assign o_lab_led = count;

    //----------------------------------------------------------------------
    // Checkerboard of 4x4 cells

    always_comb
    begin
        o_pixel = '0;  // Black outside active area

        if (lcd.de)
        begin
            if (lcd.x[2] ^ lcd.y[2])
                o_pixel.raw = '1;                    // White cell
            else
            begin
                o_pixel.rgb.red   = W_RED'(count);
                o_pixel.rgb.green = W_GREEN'(count);
                o_pixel.rgb.blue  = ~W_BLUE'(count);
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/lcd_if.sv ====
`default_nettype none

// LCD timing bundle, one source and any number of readers
interface lcd_if
#(
    parameter int w_x = 9,
    parameter int w_y = 9
);

    logic             de;  // Active area
    logic             hs;  // Active low
    logic             vs;  // Active low
    logic [w_x - 1:0] x;
    logic [w_y - 1:0] y;

    modport source
    (
        output de, hs, vs, x, y
    );

    modport sink
    (
        input  de, hs, vs, x, y
    );

endinterface

`default_nettype wire

// ==== design/lcd_timing.sv ====
`default_nettype none

module lcd_timing
#(
    parameter int screen_width  = 480,
    parameter int screen_height = 272,
    parameter int h_front       = 8,
    parameter int h_sync        = 4,
    parameter int h_back        = 43,
    parameter int v_front       = 8,
    parameter int v_sync        = 4,
    parameter int v_back        = 12
)
(
    input  wire   clk,
    input  wire   i_rst,
    lcd_if.source lcd
);

    localparam int h_total      = screen_width + h_front + h_sync + h_back;
    localparam int v_total      = screen_height + v_front + v_sync + v_back;

    localparam int h_sync_start = screen_width + h_front;
    localparam int h_sync_end   = h_sync_start + h_sync;
    localparam int v_sync_start = screen_height + v_front;
    localparam int v_sync_end   = v_sync_start + v_sync;

    localparam int w_h = $clog2(h_total);
    localparam int w_v = $clog2(v_total);
    localparam int w_x = $clog2(screen_width);
    localparam int w_y = $clog2(screen_height);

    logic [w_h - 1:0] h_cnt;
    logic [w_v - 1:0] v_cnt;

    //----------------------------------------------------------------------
    // Raster counters

    always_ff @(posedge clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            h_cnt <= '0;
            v_cnt <= '0;
        end
        else if (h_cnt == w_h'(h_total - 1))
        begin
            h_cnt <= '0;
            if (v_cnt == w_v'(v_total - 1))
                v_cnt <= '0;     // End of frame
            else
                v_cnt <= v_cnt + 1'b1;
        end
        else
            h_cnt <= h_cnt + 1'b1;
    end

    //----------------------------------------------------------------------
    // Registered outputs, one cycle behind the counters

    always_ff @(posedge clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            lcd.de <= 1'b0;
            lcd.hs <= 1'b1;
            lcd.vs <= 1'b1;
            lcd.x  <= '0;
            lcd.y  <= '0;
        end
        else
        begin
            lcd.de <= (h_cnt < screen_width) && (v_cnt < screen_height);
            lcd.hs <= !((h_cnt >= h_sync_start) && (h_cnt < h_sync_end));
            lcd.vs <= !((v_cnt >= v_sync_start) && (v_cnt < v_sync_end));
            lcd.x  <= w_x'(h_cnt);
            lcd.y  <= w_y'(v_cnt);
        end
    end

    a_x_in_screen : assert property (@(posedge clk) disable iff (i_rst)
        lcd.de |-> (lcd.x < screen_width) && (lcd.y < screen_height));

endmodule

`default_nettype wire

// ==== design/power_on_reset.sv ====
`default_nettype none

module power_on_reset
#(
    parameter int reset_cycles = 16
)
(
    input  wire  clk,
    input  wire  i_rst_n,
    output logic o_rst
);

    localparam int w_cnt = reset_cycles > 1 ? $clog2(reset_cycles) : 1;
    localparam logic [w_cnt - 1:0] last = w_cnt'(reset_cycles - 1);

    logic [w_cnt - 1:0] cnt;

    // Saturates at last, reset drops on that edge
    always_ff @(posedge clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            cnt   <= '0;
            o_rst <= 1'b1;
        end
        else if (cnt != last)
        begin
            cnt   <= cnt + 1'b1;
            o_rst <= 1'b1;
        end
        else
            o_rst <= 1'b0;
    end

    // Release only after the external reset has been high for a while
    a_no_early_release : assert property (@(posedge clk)
        $fell(o_rst) |-> i_rst_n && $past(i_rst_n));

endmodule

`default_nettype wire

// ==== design/slow_tick_gen.sv ====
`default_nettype none

module slow_tick_gen
#(
    parameter int tick_period = 27_000_000
)
(
    input  wire  clk,
    input  wire  i_rst,
    output logic o_tick
);

    //----------------------------------------------------------------------
    // Down counter, one strobe per period

    localparam int w_cnt = tick_period > 1 ? $clog2(tick_period) : 1;
    localparam logic [w_cnt - 1:0] reload = w_cnt'(tick_period - 1);

    logic [w_cnt - 1:0] cnt;

    always_ff @(posedge clk or posedge i_rst)
    begin
        if (i_rst)
            cnt <= reload;
        else if (cnt == '0)
            cnt <= reload;       // Wrap
        else
            cnt <= cnt - 1'b1;
    end

    assign o_tick = (cnt == '0);  // Stands in for the slow clock

    //----------------------------------------------------------------------

    a_single_cycle_tick : assert property (@(posedge clk) disable iff (i_rst)
        (tick_period > 1) && o_tick |=> !o_tick);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_board_top -f board_top.f

output=$(./obj_dir/Vtb_board_top)
echo "$output"

if echo "$output" | grep -qx "Finished with no errors"; then
    exit 0
fi
exit 1

// ==== verification/board_tests.txt ====
# key pins (hex, bit i = pin i, low = pressed)  hold (cycles)  count at end of hold
# pin 1 pressed counts one per tick, pin 0 pressed clears
3 40 0
1 100 5
3 60 5
1 40 7
2 20 0
1 60 3
0 60 0
1 1300 1
1 20 2
2 40 0

// ==== verification/tb_board_top.sv ====
`default_nettype none

module tb_board_top
    import board_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int screen_width  = 16;
    localparam int screen_height = 8;
    localparam int h_front       = 2;
    localparam int h_sync        = 3;
    localparam int h_back        = 3;
    localparam int v_front       = 1;
    localparam int v_sync        = 2;
    localparam int v_back        = 1;
    localparam int line_len      = screen_width + h_front + h_sync + h_back;
    localparam int tick_period   = 20;
    localparam int reset_cycles  = 16;
    localparam string tests_path = "verification/board_tests.txt";

    logic                 clk;
    logic                 i_rst_n;
    logic [W_KEY   - 1:0] i_key;
    logic [W_LED   - 1:0] o_led;
    logic                 o_lcd_de;
    logic                 o_lcd_hs;
    logic                 o_lcd_vs;
    logic [W_RED   - 1:0] o_lcd_r;
    logic [W_GREEN - 1:0] o_lcd_g;
    logic [W_BLUE  - 1:0] o_lcd_b;

    logic [W_KEY - 1:0] test_pins [$];
    int                 test_hold [$];
    int                 test_count [$];
    int                 total_hold;
    bit                 tests_loaded;

    logic               rst_n_drive;
    int                 released;       // Edges since i_rst_n went high
    int                 model_count;
    bit                 prev_de;
    int                 de_in_line;     // Raw x of the next active pixel
    int                 line_in_frame;  // Raw y
    int                 hs_low_run;
    int                 vs_low_run;
    int                 value_errors;
    int                 other_errors;
    int                 seed;

    tb_clock_gen #(.period(8.0)) clock_gen (.clk(clk));

    board_top
    #(
        .tick_period   ( tick_period   ),
        .reset_cycles  ( reset_cycles  ),
        .screen_width  ( screen_width  ),
        .screen_height ( screen_height ),
        .h_front       ( h_front       ),
        .h_sync        ( h_sync        ),
        .h_back        ( h_back        ),
        .v_front       ( v_front       ),
        .v_sync        ( v_sync        ),
        .v_back        ( v_back        )
    )
    DUT
    (
        .clk      ( clk      ),
        .i_rst_n  ( i_rst_n  ),
        .i_key    ( i_key    ),
        .o_led    ( o_led    ),
        .o_lcd_de ( o_lcd_de ),
        .o_lcd_hs ( o_lcd_hs ),
        .o_lcd_vs ( o_lcd_vs ),
        .o_lcd_r  ( o_lcd_r  ),
        .o_lcd_g  ( o_lcd_g  ),
        .o_lcd_b  ( o_lcd_b  )
    );

    //----------------------------------------------------------------------
    // Reporting

    task automatic report_mismatch(input string name, input logic [15:0] actual,
                                   input logic [15:0] expected);
        value_errors++;
        $display("error at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
    endtask

    task automatic report_failure(input string what);
        other_errors++;
        $display("%s (at %0d ns)", what, $time);
    endtask

    //----------------------------------------------------------------------
    // Test table, one line per key hold

    task automatic load_tests();
        int                 fd;
        int                 n;
        int                 hold;
        int                 count;
        logic [W_KEY - 1:0] pins;
        string              text;

        fd = $fopen(tests_path, "r");
        if (fd == 0)
        begin
            report_failure({"Cannot open the test table ", tests_path});
            return;
        end
        while (!$feof(fd))
        begin
            n = $fgets(text, fd);
            if (n > 0 && $sscanf(text, "%h %d %d", pins, hold, count) == 3)
            begin
                test_pins.push_back(pins);
                test_hold.push_back(hold);
                test_count.push_back(count);
                total_hold += hold;
            end
        end
        $fclose(fd);
        if (test_hold.size() == 0)
            report_failure("The test table holds no tests");
    endtask

    //----------------------------------------------------------------------
    // Reference model, stepped once per rising edge

    // Pins are active low and wired in reverse order
    function automatic logic [W_LED - 1:0] led_pins(input int count);
        logic [W_LED - 1:0] pins;
        int                 i;

        for (i = 0; i < W_LED; i++)
            pins[i] = !count[W_LED - 1 - i];
        return pins;
    endfunction

    task automatic update_model();
        bit tick;

        if (!i_rst_n)
        begin
            released    = 0;
            model_count = 0;
        end
        else
        begin
            released++;
            tick = released > reset_cycles && (released - reset_cycles) % tick_period == 0;
            if (!i_key[0])
                model_count = 0;                          // Pin 0 clears
            else if (tick && !i_key[1])
                model_count = (model_count + 1) % 64;
        end
    endtask

    task automatic check_outputs();
        int                 x;
        int                 y;
        logic [W_RED   - 1:0] exp_r;
        logic [W_GREEN - 1:0] exp_g;
        logic [W_BLUE  - 1:0] exp_b;

        if (released <= reset_cycles)
        begin
            if (o_lcd_de !== 1'b0)
                report_mismatch("o_lcd_de", o_lcd_de, 1'b0);
            if (o_lcd_hs !== 1'b1)
                report_mismatch("o_lcd_hs", o_lcd_hs, 1'b1);
            if (o_lcd_vs !== 1'b1)
                report_mismatch("o_lcd_vs", o_lcd_vs, 1'b1);
        end
        else if (released == reset_cycles + 1 && o_lcd_de !== 1'b1)
            report_mismatch("o_lcd_de", o_lcd_de, 1'b1);

        if (o_led !== led_pins(model_count))
            report_mismatch("o_led", o_led, led_pins(model_count));

        exp_r = '0;
        exp_g = '0;
        exp_b = '0;
        if (o_lcd_de)
        begin
            x = screen_width  - 1 - de_in_line;  // Panel is mirrored
            y = screen_height - 1 - line_in_frame;
            if (x[2] ^ y[2])
            begin
                exp_r = '1;
                exp_g = '1;
                exp_b = '1;
            end
            else
            begin
                exp_r = model_count[W_RED - 1:0];
                exp_g = model_count[W_GREEN - 1:0];
                exp_b = ~model_count[W_BLUE - 1:0];
            end
        end
        if (o_lcd_r !== exp_r)
            report_mismatch("o_lcd_r", o_lcd_r, exp_r);
        if (o_lcd_g !== exp_g)
            report_mismatch("o_lcd_g", o_lcd_g, exp_g);
        if (o_lcd_b !== exp_b)
            report_mismatch("o_lcd_b", o_lcd_b, exp_b);

        // Raster shape
        if (o_lcd_de)
            de_in_line++;
        else if (prev_de)
        begin
            if (de_in_line != screen_width)
                report_failure("A line has the wrong number of active pixels");
            de_in_line = 0;
            line_in_frame++;
        end
        prev_de = o_lcd_de;

        if (!o_lcd_hs)
            hs_low_run++;
        else if (hs_low_run != 0)
        begin
            if (hs_low_run != h_sync)
                report_failure("Horizontal sync pulse has the wrong length");
            hs_low_run = 0;
        end

        if (!o_lcd_vs)
        begin
            if (vs_low_run == 0 && line_in_frame != screen_height)
                report_failure("A frame has the wrong number of active lines");
            vs_low_run++;
            line_in_frame = 0;
        end
        else if (vs_low_run != 0)
        begin
            if (vs_low_run != v_sync * line_len)
                report_failure("Vertical sync pulse is not two whole lines");
            vs_low_run = 0;
        end
    endtask

    task automatic run_cycle(input logic [W_KEY - 1:0] pins);
        @(posedge clk);
        update_model();
        i_rst_n <= rst_n_drive;
        i_key   <= pins;
        @(negedge clk);
        check_outputs();
    endtask

    //----------------------------------------------------------------------

    initial
    begin
        int i;
        int gap;

        i_rst_n      = 1'b0;
        i_key        = '1;   // No key pressed
        rst_n_drive  = 1'b0;
        seed         = 69841;
        value_errors = 0;
        other_errors = 0;
        total_hold   = 0;
        load_tests();
        tests_loaded = 1'b1;

        for (i = 0; i < 10; i++)
        begin
            rst_n_drive = (i == 9);
            run_cycle('1);
        end
        repeat (20)
            run_cycle('1);   // Internal reset stretch

        // Idle gaps are whole tick periods, keeping the tick phase
        for (i = 0; i < test_hold.size(); i++)
        begin
            repeat (test_hold[i])
                run_cycle(test_pins[i]);
            if (model_count != test_count[i])
                report_failure($sformatf("Test %0d: model count %0d, table expects %0d",
                                         i, model_count, test_count[i]));
            if (o_led !== led_pins(test_count[i]))
                report_mismatch("o_led", o_led, led_pins(test_count[i]));
            gap = tick_period * ({$random(seed)} % 4);
            repeat (gap)
                run_cycle('1);
        end

        $display("Tests: %0d, value errors: %0d, other errors: %0d",
                 test_hold.size(), value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

    initial
    begin
        wait (tests_loaded);
        repeat (total_hold + 2000)
            @(posedge clk);
        $display("Watchdog expired before the tests completed");
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen
#(
    parameter real period = 8.0  // ns
)
(
    output logic clk
);

    timeunit 1ns;
    timeprecision 1ps;

    initial
    begin
        clk = 1'b0;
        forever
            #(period / 2.0) clk = ~clk;
    end

endmodule

`default_nettype wire
